// File: common/mdu_macros.svh
`ifndef MDU_MACROS_SVH
`define MDU_MACROS_SVH

////////////////////////////////////////
// multiply/divide unit sizing
////////////////////////////////////////

// operand and result width
`define MDU_XLEN 32

// restoring divider, one quotient bit per iteration
`define MDU_DIV_STEPS 32

`endif

// File: common/rv_m_pkg.sv
package rv_m_pkg;

    // funct3 of the M extension (OP opcode, funct7 = 0000001)
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } mdu_op_e;

    function automatic logic is_mul_op(mdu_op_e op);
        return !op[2];                  // funct3[2] splits mul from div
    endfunction

    function automatic logic is_signed_div(mdu_op_e op);
        return op inside {DIV, REM};
    endfunction

    function automatic logic is_rem_op(mdu_op_e op);
        return op inside {REM, REMU};
    endfunction

endpackage

// File: common/mdu_ctrl_pkg.sv
package mdu_ctrl_pkg;

    // multiplier: one stall cycle, then the registered product
    typedef enum logic {
        M_IDLE = 1'b0,
        M_CALC = 1'b1
    } mul_state_e;

    // divider sequencing
    // the core walks idle -> calc -> done, the sign stage adds D_SIGN
    typedef enum logic [1:0] {
        D_IDLE = 2'd0,
        D_CALC = 2'd1,
        D_SIGN = 2'd2,
        D_DONE = 2'd3
    } div_state_e;

endpackage

// File: hdl/mdu_mul.sv
`timescale 1ns/1ps
`include "mdu_macros.svh"

module mdu_mul (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start_i,
    input  rv_m_pkg::mdu_op_e       op_i,
    input  logic [`MDU_XLEN-1:0]    rs1_i,
    input  logic [`MDU_XLEN-1:0]    rs2_i,
    output logic                    hold_o,
    output logic [`MDU_XLEN-1:0]    result_o
);

    localparam int XLEN = `MDU_XLEN;

    mdu_ctrl_pkg::mul_state_e   state_q;

    logic [2*XLEN-1:0]  rs1_zext;
    logic [2*XLEN-1:0]  rs2_zext;
    logic [2*XLEN-1:0]  rs1_sext;
    logic [2*XLEN-1:0]  rs2_sext;

    logic [2*XLEN-1:0]  prod_uu_q;
    logic [2*XLEN-1:0]  prod_ss_q;
    logic [2*XLEN-1:0]  prod_su_q;

////////////////////////////////////////
// stall control
////////////////////////////////////////

    assign hold_o = (state_q == mdu_ctrl_pkg::M_IDLE) && start_i;  // stall the start cycle only

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= mdu_ctrl_pkg::M_IDLE;
        end else if (hold_o) begin
            state_q <= mdu_ctrl_pkg::M_CALC;
        end else begin
            state_q <= mdu_ctrl_pkg::M_IDLE;     // result cycle, back to idle
        end
    end

////////////////////////////////////////
// products
////////////////////////////////////////

    // 64-bit extension makes a plain modulo-2^64 multiply exact
    assign rs1_zext = {{XLEN{1'b0}}, rs1_i};
    assign rs2_zext = {{XLEN{1'b0}}, rs2_i};
    assign rs1_sext = {{XLEN{rs1_i[XLEN-1]}}, rs1_i};
    assign rs2_sext = {{XLEN{rs2_i[XLEN-1]}}, rs2_i};

    always_ff @(posedge clk) begin
        prod_uu_q <= rs1_zext * rs2_zext;
        prod_ss_q <= rs1_sext * rs2_sext;
        prod_su_q <= rs1_sext * rs2_zext;
    end

    always_comb begin
        case (op_i)
            rv_m_pkg::MULH: begin
                result_o = prod_ss_q[2*XLEN-1:XLEN];
            end
            rv_m_pkg::MULHSU: begin
                result_o = prod_su_q[2*XLEN-1:XLEN];
            end
            rv_m_pkg::MULHU: begin
                result_o = prod_uu_q[2*XLEN-1:XLEN];
            end
            default: begin
                result_o = prod_uu_q[XLEN-1:0];  // low word is sign independent
            end
        endcase
    end

    // the result cycle selects its word with the op of the start cycle
    op_held_a : assert property (@(posedge clk) disable iff (reset)
        hold_o |=> start_i && $stable(op_i));

endmodule

// File: divider/div_core.sv
`timescale 1ns/1ps
`include "mdu_macros.svh"

module div_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start_i,
    input  logic [`MDU_XLEN-1:0]    dividend_i,
    input  logic [`MDU_XLEN-1:0]    divisor_i,
    output logic                    busy_o,
    output logic                    done_o,
    output logic [`MDU_XLEN-1:0]    quotient_o,
    output logic [`MDU_XLEN-1:0]    remainder_o
);

    localparam int         XLEN      = `MDU_XLEN;
    localparam logic [4:0] LAST_STEP = 5'(`MDU_DIV_STEPS - 1);

    mdu_ctrl_pkg::div_state_e   state_q;
    logic [4:0]                 step_q;

    logic               load;
    logic               fits;
    logic [XLEN:0]      acc_q;
    logic [XLEN:0]      acc_in;
    logic [XLEN:0]      acc_next;
    logic [XLEN-1:0]    quo_q;
    logic [XLEN-1:0]    quo_in;
    logic [XLEN-1:0]    quo_next;
    logic [XLEN-1:0]    divisor_q;
    logic [XLEN-1:0]    divisor_in;
    logic [XLEN+1:0]    shifted;

    assign busy_o = (state_q == mdu_ctrl_pkg::D_CALC);
    assign done_o = (state_q == mdu_ctrl_pkg::D_DONE);
    assign load   = start_i && !busy_o;

////////////////////////////////////////
// sequencing
////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= mdu_ctrl_pkg::D_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                mdu_ctrl_pkg::D_CALC: begin
                    step_q <= step_q + 5'd1;
                    if (step_q == LAST_STEP) begin
                        state_q <= mdu_ctrl_pkg::D_DONE;
                    end
                end
                default: begin
                    if (load) begin
                        state_q <= mdu_ctrl_pkg::D_CALC;
                        step_q  <= 5'd1;         // first step happens on load
                    end else begin
                        state_q <= mdu_ctrl_pkg::D_IDLE;
                    end
                end
            endcase
        end
    end

////////////////////////////////////////
// restoring step
////////////////////////////////////////

    assign acc_in     = load ? '0 : acc_q;
    assign quo_in     = load ? dividend_i : quo_q;
    assign divisor_in = load ? divisor_i : divisor_q;

    assign shifted  = {acc_in, quo_in[XLEN-1]};
    assign fits     = shifted >= {2'b00, divisor_in};
    assign acc_next = fits ? shifted[XLEN:0] - {1'b0, divisor_in} : shifted[XLEN:0];
    assign quo_next = {quo_in[XLEN-2:0], fits};

    always_ff @(posedge clk) begin
        if (load || busy_o) begin
            acc_q     <= acc_next;
            quo_q     <= quo_next;
            divisor_q <= divisor_in;
        end
    end

    assign quotient_o  = quo_q;
    assign remainder_o = acc_q[XLEN-1:0];    // remainder < divisor, top bit stays clear

    start_while_free_a : assert property (@(posedge clk) disable iff (reset)
        start_i |-> !busy_o);

    done_single_pulse_a : assert property (@(posedge clk) disable iff (reset)
        done_o |-> $fell(busy_o) ##1 !done_o);

endmodule

// File: divider/div_sign.sv
`timescale 1ns/1ps
`include "mdu_macros.svh"

module div_sign (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start_i,
    input  rv_m_pkg::mdu_op_e       op_i,
    input  logic [`MDU_XLEN-1:0]    rs1_i,
    input  logic [`MDU_XLEN-1:0]    rs2_i,
    output logic                    hold_o,
    output logic [`MDU_XLEN-1:0]    result_o
);

    localparam int              XLEN     = `MDU_XLEN;
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    mdu_ctrl_pkg::div_state_e   state_q;

    logic               signed_op;
    logic               rem_op;
    logic               div_by_zero;
    logic               overflow;
    logic               special;
    logic               accept;
    logic [XLEN-1:0]    special_result;

    logic               core_start;
    logic               core_busy;
    logic               core_done;
    logic [XLEN-1:0]    dividend_mag;
    logic [XLEN-1:0]    divisor_mag;
    logic [XLEN-1:0]    core_quotient;
    logic [XLEN-1:0]    core_remainder;

    logic               quo_neg_q;
    logic               rem_neg_q;
    logic [XLEN-1:0]    signed_quo;
    logic [XLEN-1:0]    signed_rem;
    logic [XLEN-1:0]    result_q;

////////////////////////////////////////
// request decode
////////////////////////////////////////

    assign signed_op   = rv_m_pkg::is_signed_div(op_i);
    assign rem_op      = rv_m_pkg::is_rem_op(op_i);
    assign div_by_zero = (rs2_i == '0);
    assign overflow    = signed_op && (rs1_i == MOST_NEG) && (rs2_i == '1);
    assign special     = div_by_zero || overflow;
    assign accept      = (state_q == mdu_ctrl_pkg::D_IDLE) && start_i;

    always_comb begin
        if (div_by_zero) begin
            special_result = rem_op ? rs1_i : '1;    // quotient all ones
        end else begin
            special_result = rem_op ? '0 : rs1_i;    // most negative / -1
        end
    end

    assign dividend_mag = (signed_op && rs1_i[XLEN-1]) ? -rs1_i : rs1_i;
    assign divisor_mag  = (signed_op && rs2_i[XLEN-1]) ? -rs2_i : rs2_i;
    assign core_start   = accept && !special;

    div_core u_core (
        .clk         (clk),
        .reset       (reset),
        .start_i     (core_start),
        .dividend_i  (dividend_mag),
        .divisor_i   (divisor_mag),
        .busy_o      (core_busy),
        .done_o      (core_done),
        .quotient_o  (core_quotient),
        .remainder_o (core_remainder)
    );

////////////////////////////////////////
// sequencing and result
////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= mdu_ctrl_pkg::D_IDLE;
        end else begin
            case (state_q)
                mdu_ctrl_pkg::D_IDLE: begin
                    if (start_i) begin
                        state_q <= special ? mdu_ctrl_pkg::D_DONE : mdu_ctrl_pkg::D_CALC;
                    end
                end
                mdu_ctrl_pkg::D_CALC: begin
                    if (core_done) begin
                        state_q <= mdu_ctrl_pkg::D_SIGN;
                    end
                end
                mdu_ctrl_pkg::D_SIGN: begin
                    state_q <= mdu_ctrl_pkg::D_DONE;
                end
                default: begin
                    state_q <= mdu_ctrl_pkg::D_IDLE;     // result cycle
                end
            endcase
        end
    end

    assign signed_quo = quo_neg_q ? -core_quotient : core_quotient;
    assign signed_rem = rem_neg_q ? -core_remainder : core_remainder;  // follows dividend

    always_ff @(posedge clk) begin
        if (accept) begin
            quo_neg_q <= signed_op && (rs1_i[XLEN-1] ^ rs2_i[XLEN-1]);
            rem_neg_q <= signed_op && rs1_i[XLEN-1];
            result_q  <= special_result;
        end else if (state_q == mdu_ctrl_pkg::D_SIGN) begin
            result_q  <= rem_op ? signed_rem : signed_quo;
        end
    end

    assign hold_o   = accept
                    || (state_q == mdu_ctrl_pkg::D_CALC)
                    || (state_q == mdu_ctrl_pkg::D_SIGN);
    assign result_o = result_q;

    // the core must be working for as long as this stage waits on it
    calc_tracks_core_a : assert property (@(posedge clk) disable iff (reset)
        (state_q == mdu_ctrl_pkg::D_CALC) |-> (core_busy || core_done));

endmodule

// File: hdl/mdu_top.sv
`timescale 1ns/1ps
`include "mdu_macros.svh"

module mdu_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    valid_i,
    input  rv_m_pkg::mdu_op_e       op_i,
    input  logic [`MDU_XLEN-1:0]    rs1_i,
    input  logic [`MDU_XLEN-1:0]    rs2_i,
    output logic                    hold_o,
    output logic [`MDU_XLEN-1:0]    result_o
);

    logic                   is_mul;
    logic                   mul_start;
    logic                   div_start;
    logic                   mul_hold;
    logic                   div_hold;
    logic [`MDU_XLEN-1:0]   mul_result;
    logic [`MDU_XLEN-1:0]   div_result;

////////////////////////////////////////
// op routing
////////////////////////////////////////

    assign is_mul    = rv_m_pkg::is_mul_op(op_i);
    assign mul_start = valid_i && is_mul;
    assign div_start = valid_i && !is_mul;

    mdu_mul u_mul (
        .clk      (clk),
        .reset    (reset),
        .start_i  (mul_start),
        .op_i     (op_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .hold_o   (mul_hold),
        .result_o (mul_result)
    );

    div_sign u_div (
        .clk      (clk),
        .reset    (reset),
        .start_i  (div_start),
        .op_i     (op_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .hold_o   (div_hold),
        .result_o (div_result)
    );

    assign hold_o   = mul_hold || div_hold;
    assign result_o = is_mul ? mul_result : div_result;  // owner of the current op

    // a request goes to exactly one block, so the stalls never overlap
    single_owner_a : assert property (@(posedge clk) disable iff (reset)
        !(mul_hold && div_hold));

endmodule

// File: test/mdu_tb.sv
`timescale 1ns/1ps
`include "mdu_macros.svh"

module mdu_tb;

    localparam int XLEN           = `MDU_XLEN;
    localparam int NUM_REQ        = 400;
    localparam int RESET_CYCLES   = 4;
    localparam int IDLE_CYCLES    = 8;
    localparam int DIV_LATENCY    = `MDU_DIV_STEPS + 2;     // start, iterations, sign stage
    localparam int TIMEOUT_CYCLES = NUM_REQ * (`MDU_DIV_STEPS + 4) + RESET_CYCLES + IDLE_CYCLES;

    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};
    localparam logic [XLEN-1:0] MOST_POS = {1'b0, {(XLEN-1){1'b1}}};

    logic                   clk;
    logic                   reset;
    logic                   valid_i;
    rv_m_pkg::mdu_op_e      op_i;
    logic [XLEN-1:0]        rs1_i;
    logic [XLEN-1:0]        rs2_i;
    logic                   hold_o;
    logic [XLEN-1:0]        result_o;

    integer seed;
    int     cycle_cnt;
    int     result_errors;
    int     latency_errors;
    int     other_errors;
    int     n_mul;
    int     n_div;
    int     n_zero;
    int     n_ovf;
    int     n_repeat;

    mdu_top i_dut (
        .clk      (clk),
        .reset    (reset),
        .valid_i  (valid_i),
        .op_i     (op_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .hold_o   (hold_o),
        .result_o (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

////////////////////////////////////////
// reference model
////////////////////////////////////////

    function automatic logic [XLEN-1:0] model_result(rv_m_pkg::mdu_op_e op,
                                                     logic [XLEN-1:0] a,
                                                     logic [XLEN-1:0] b);
        logic signed [2*XLEN-1:0]   sa;
        logic signed [2*XLEN-1:0]   sb;
        logic signed [2*XLEN-1:0]   sq;
        logic signed [2*XLEN-1:0]   sr;
        logic [2*XLEN-1:0]          ua;
        logic [2*XLEN-1:0]          ub;
        logic [2*XLEN-1:0]          full;
        logic                       ovf;
        sa   = $signed(a);
        sb   = $signed(b);
        ua   = {{XLEN{1'b0}}, a};
        ub   = {{XLEN{1'b0}}, b};
        ovf  = (a == MOST_NEG) && (b == '1);
        sq   = '0;
        sr   = '0;
        if (b != '0) begin
            sq = sa / sb;                                   // signed quotient, truncated
            sr = sa % sb;
        end
        full = '0;
        case (op)
            rv_m_pkg::MUL:    full = ua * ub;
            rv_m_pkg::MULH:   full = (sa * sb) >> XLEN;
            rv_m_pkg::MULHSU: full = (sa * ub) >> XLEN;     // product fits in 64 signed bits
            rv_m_pkg::MULHU:  full = (ua * ub) >> XLEN;
            rv_m_pkg::DIV:    full = (b == '0) ? '1 : (ovf ? ua : sq);
            rv_m_pkg::DIVU:   full = (b == '0) ? '1 : ua / ub;
            rv_m_pkg::REM:    full = (b == '0) ? ua : (ovf ? '0 : sr);
            default:          full = (b == '0) ? ua : ua % ub;
        endcase
        return full[XLEN-1:0];
    endfunction

    function automatic int model_latency(rv_m_pkg::mdu_op_e op,
                                         logic [XLEN-1:0] a,
                                         logic [XLEN-1:0] b);
        if (op inside {rv_m_pkg::MUL, rv_m_pkg::MULH, rv_m_pkg::MULHSU, rv_m_pkg::MULHU}) begin
            return 1;
        end
        if (b == '0) begin
            return 1;                                       // divide by zero
        end
        if ((op inside {rv_m_pkg::DIV, rv_m_pkg::REM}) && (a == MOST_NEG) && (b == '1)) begin
            return 1;                                       // signed overflow
        end
        return DIV_LATENCY;
    endfunction

////////////////////////////////////////
// checks
////////////////////////////////////////

    task automatic check_result(input string test, input logic [XLEN-1:0] expected,
                                input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            result_errors++;
            $display("Fail %s result: expected %h, actual %h", test, expected, actual);
        end
    endtask

    task automatic check_latency(input string test, input int expected, input int actual);
        if (actual != expected) begin
            latency_errors++;
            $display("Fail %s latency: expected %0d, actual %0d", test, expected, actual);
        end
    endtask

////////////////////////////////////////
// stimulus
////////////////////////////////////////

    task automatic pick_operand(output logic [XLEN-1:0] v);
        int k;
        k = $unsigned($random(seed)) % 8;
        case (k)
            0:       v = '0;
            1:       v = 1;
            2:       v = '1;
            3:       v = MOST_NEG;
            4:       v = MOST_POS;
            default: v = $random(seed);
        endcase
    endtask

    task automatic make_request(output rv_m_pkg::mdu_op_e op, output logic [XLEN-1:0] a,
                                output logic [XLEN-1:0] b);
        int          kind;
        logic [31:0] r;
        r    = $random(seed);
        kind = $unsigned($random(seed)) % 16;
        op   = rv_m_pkg::mdu_op_e'(r[2:0]);
        pick_operand(a);
        pick_operand(b);
        if (kind == 0) begin
            a  = MOST_NEG;                                  // force the overflow case
            b  = '1;
            op = r[3] ? rv_m_pkg::DIV : rv_m_pkg::REM;
        end else if (kind == 1) begin
            b  = '0;
            op = rv_m_pkg::mdu_op_e'({1'b1, r[1:0]});       // any divide op
        end
    endtask

    task automatic check_idle_hold(input int cycles);
        logic [31:0] r;
        repeat (cycles) begin
            @(posedge clk);
            r = $random(seed);
            op_i  <= rv_m_pkg::mdu_op_e'(r[2:0]);
            rs1_i <= $random(seed);
            rs2_i <= r;
            @(negedge clk);
            if (hold_o) begin
                other_errors++;
                $display("error: hold_o is high at %0t although valid_i is low", $time);
            end
        end
    endtask

    task automatic run_request(input rv_m_pkg::mdu_op_e op, input logic [XLEN-1:0] a,
                               input logic [XLEN-1:0] b, input string test);
        int              lat;
        int              exp_lat;
        logic [XLEN-1:0] exp_result;
        exp_result = model_result(op, a, b);
        exp_lat    = model_latency(op, a, b);
        @(posedge clk);
        valid_i <= 1'b1;
        op_i    <= op;
        rs1_i   <= a;
        rs2_i   <= b;
        lat = 0;
        @(negedge clk);
        while (hold_o) begin                                // watchdog bounds this wait
            lat++;
            @(negedge clk);
        end
        check_result(test, exp_result, result_o);
        check_latency(test, exp_lat, lat);
    endtask

    initial begin : stimulus
        rv_m_pkg::mdu_op_e  op;
        logic [XLEN-1:0]    a;
        logic [XLEN-1:0]    b;
        string              name;
        seed           = 32'h67be;
        result_errors  = 0;
        latency_errors = 0;
        other_errors   = 0;
        n_mul          = 0;
        n_div          = 0;
        n_zero         = 0;
        n_ovf          = 0;
        n_repeat       = 0;
        reset          = 1'b1;
        valid_i        = 1'b0;
        op_i           = rv_m_pkg::MUL;
        rs1_i          = '0;
        rs2_i          = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        check_idle_hold(IDLE_CYCLES);
        for (int i = 0; i < NUM_REQ; i++) begin
            if (i == 0 || ($unsigned($random(seed)) % 8) != 0) begin
                make_request(op, a, b);
            end else begin
                n_repeat++;                                 // same request again back to back
            end
            if (op inside {rv_m_pkg::MUL, rv_m_pkg::MULH, rv_m_pkg::MULHSU, rv_m_pkg::MULHU}) begin
                n_mul++;
            end else if (b == '0) begin
                n_zero++;
            end else if (model_latency(op, a, b) == 1) begin
                n_ovf++;
            end else begin
                n_div++;
            end
            name = $sformatf("req %0d %s", i, op.name());
            run_request(op, a, b, name);
        end
        @(posedge clk);
        valid_i <= 1'b0;
        check_idle_hold(2);
        if (n_mul == 0 || n_div == 0 || n_zero == 0 || n_ovf == 0 || n_repeat == 0) begin
            other_errors++;
            $display("error: request mix incomplete (mul %0d, div %0d, zero %0d, ovf %0d, rep %0d)",
                     n_mul, n_div, n_zero, n_ovf, n_repeat);
        end
        $display("errors: result %0d, latency %0d, other %0d",
                 result_errors, latency_errors, other_errors);
        if (result_errors + latency_errors + other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        other_errors++;
        $display("error: the unit stopped answering, run ended after %0d cycles", cycle_cnt);
        $display("errors: result %0d, latency %0d, other %0d",
                 result_errors, latency_errors, other_errors);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+common
common/rv_m_pkg.sv
common/mdu_ctrl_pkg.sv
hdl/mdu_mul.sv
divider/div_core.sv
divider/div_sign.sv
hdl/mdu_top.sv
test/mdu_tb.sv

// File: Makefile
# Verilator build and run for the multiply/divide unit

VERILATOR  ?= verilator
TOP        ?= mdu_tb
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Some tests failed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
